//--- la_pkg.sv
`default_nettype none

package la_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  mem_idx_t;
    typedef logic [11:0] alu_op_t;
    typedef logic        src_t;

    localparam int    MEM_WORDS    = 256;
    localparam int    SRAM_QDEPTH  = 2;
    localparam int    SRAM_QPTR_W  = $clog2(SRAM_QDEPTH);
    localparam int    PORT_CREDITS = 1;
    localparam int    CREDIT_W     = $clog2(SRAM_QDEPTH + 1);
    localparam word_t RESET_PC     = 32'h1c00_0000; // maps to word 0

    typedef logic [CREDIT_W-1:0] credit_t;

    localparam src_t SRC_CORE = 1'b0;
    localparam src_t SRC_HOST = 1'b1;

    // bit positions in the one-hot alu select
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
        src_t  src;
    } mem_req_t;

    typedef struct packed {
        word_t rdata;
        src_t  src;
    } mem_rsp_t;

    typedef struct packed {
        alu_op_t  alu_op;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     src_reg_is_rd;
        logic     res_from_mem;
        logic     gr_we;
        logic     mem_we;
        logic     is_load;
        logic     is_store;
        logic     is_beq;
        logic     is_bne;
        logic     is_jirl;
        logic     is_jump;
        reg_idx_t dest;
        reg_idx_t rj;
        reg_idx_t rkd;
        word_t    imm;
        word_t    br_offs;
    } decoded_t;

    typedef struct packed {
        word_t    pc;
        logic     we;
        reg_idx_t wnum;
        word_t    wdata;
    } retire_t;

    typedef enum logic [2:0] {
        IDLE, FETCH, FWAIT, DECODE, EXEC, MEM, MWAIT, WB
    } core_state_e;

endpackage

`default_nettype wire

//--- la_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module la_decoder
    import la_pkg::*;
(
    input  wire word_t inst,
    output decoded_t   dec
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        is_3r;
    logic        is_shift;
    logic        inst_add_w;
    logic        inst_sub_w;
    logic        inst_slt;
    logic        inst_sltu;
    logic        inst_nor;
    logic        inst_and;
    logic        inst_or;
    logic        inst_xor;
    logic        inst_slli_w;
    logic        inst_srli_w;
    logic        inst_srai_w;
    logic        inst_addi_w;
    logic        inst_ld_w;
    logic        inst_st_w;
    logic        inst_jirl;
    logic        inst_b;
    logic        inst_bl;
    logic        inst_beq;
    logic        inst_bne;
    logic        inst_lu12i_w;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]}; // offs[25:16] sits in the low bits

    assign is_3r    = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign is_shift = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = is_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = is_3r && (op_19_15 == 5'h02);
    assign inst_slt     = is_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = is_3r && (op_19_15 == 5'h05);
    assign inst_nor     = is_3r && (op_19_15 == 5'h08);
    assign inst_and     = is_3r && (op_19_15 == 5'h09);
    assign inst_or      = is_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = is_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = is_shift && (op_19_15 == 5'h01);
    assign inst_srli_w  = is_shift && (op_19_15 == 5'h09);
    assign inst_srai_w  = is_shift && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];

    // address generation and the link value both go through the adder
    assign dec.alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                | inst_jirl | inst_bl;
    assign dec.alu_op[ALU_SUB]  = inst_sub_w;
    assign dec.alu_op[ALU_SLT]  = inst_slt;
    assign dec.alu_op[ALU_SLTU] = inst_sltu;
    assign dec.alu_op[ALU_AND]  = inst_and;
    assign dec.alu_op[ALU_NOR]  = inst_nor;
    assign dec.alu_op[ALU_OR]   = inst_or;
    assign dec.alu_op[ALU_XOR]  = inst_xor;
    assign dec.alu_op[ALU_SLL]  = inst_slli_w;
    assign dec.alu_op[ALU_SRL]  = inst_srli_w;
    assign dec.alu_op[ALU_SRA]  = inst_srai_w;
    assign dec.alu_op[ALU_LUI]  = inst_lu12i_w;

    assign dec.src1_is_pc    = inst_jirl | inst_bl | inst_b;
    assign dec.src2_is_imm   = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                             | inst_ld_w | inst_st_w | inst_lu12i_w | inst_jirl
                             | inst_bl | inst_b;
    assign dec.src_reg_is_rd = inst_beq | inst_bne | inst_st_w;
    assign dec.res_from_mem  = inst_ld_w;
    assign dec.gr_we         = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor
                             | inst_and | inst_or | inst_xor | inst_slli_w | inst_srli_w
                             | inst_srai_w | inst_addi_w | inst_ld_w | inst_jirl | inst_bl
                             | inst_lu12i_w; // unknown encodings write nothing
    assign dec.mem_we        = inst_st_w;
    assign dec.is_load       = inst_ld_w;
    assign dec.is_store      = inst_st_w;
    assign dec.is_beq        = inst_beq;
    assign dec.is_bne        = inst_bne;
    assign dec.is_jirl       = inst_jirl;
    assign dec.is_jump       = inst_b | inst_bl;

    assign dec.dest = inst_bl ? 5'd1 : rd;
    assign dec.rj   = rj;
    assign dec.rkd  = dec.src_reg_is_rd ? rd : rk;

    assign dec.imm = (inst_jirl | inst_bl) ? 32'd4 :
                     inst_lu12i_w          ? {i20, 12'b0} :
                                             {{20{i12[11]}}, i12};

    assign dec.br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                              {{14{i16[15]}}, i16, 2'b0};

endmodule

`default_nettype wire

//--- la_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module la_regfile
    import la_pkg::*;
(
    input  wire           clk,
    input  wire reg_idx_t raddr1,
    input  wire reg_idx_t raddr2,
    input  wire reg_idx_t waddr,
    input  wire           we,
    input  wire word_t    wdata,
    output word_t         rdata1,
    output word_t         rdata2
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- la_alu.sv
`timescale 1ns/10ps
`default_nettype none

module la_alu
    import la_pkg::*;
(
    input  wire alu_op_t alu_op,
    input  wire word_t   src1,
    input  wire word_t   src2,
    output word_t        result
);

    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src2[4:0];

    // the select is one-hot, so the terms can simply be ored together
    assign result = ({32{alu_op[ALU_ADD]}}  & sum)
                  | ({32{alu_op[ALU_SUB]}}  & diff)
                  | ({32{alu_op[ALU_SLT]}}  & {31'b0, $signed(src1) < $signed(src2)})
                  | ({32{alu_op[ALU_SLTU]}} & {31'b0, src1 < src2})
                  | ({32{alu_op[ALU_AND]}}  & (src1 & src2))
                  | ({32{alu_op[ALU_NOR]}}  & ~(src1 | src2))
                  | ({32{alu_op[ALU_OR]}}   & (src1 | src2))
                  | ({32{alu_op[ALU_XOR]}}  & (src1 ^ src2))
                  | ({32{alu_op[ALU_SLL]}}  & (src1 << shamt))
                  | ({32{alu_op[ALU_SRL]}}  & (src1 >> shamt))
                  | ({32{alu_op[ALU_SRA]}}  & word_t'($signed(src1) >>> shamt))
                  | ({32{alu_op[ALU_LUI]}}  & src2);

endmodule

`default_nettype wire

//--- la_core.sv
`timescale 1ns/10ps
`default_nettype none

module la_core
    import la_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire           run,
    output logic          req_valid,
    output mem_req_t      req,
    input  wire           req_credit,
    input  wire           rsp_valid,
    input  wire mem_rsp_t rsp,
    output logic          retire_valid,
    output retire_t       retire
);

    core_state_e state;
    word_t       pc;
    word_t       next_pc;
    word_t       inst;
    word_t       rj_val;
    word_t       rkd_val;
    word_t       alu_res;
    word_t       load_data;
    decoded_t    dec;
    decoded_t    dec_q;
    credit_t     credits;
    word_t       rf_rdata1;
    word_t       rf_rdata2;
    word_t       alu_src1;
    word_t       alu_src2;
    word_t       alu_out;
    word_t       wb_data;
    word_t       br_target;
    logic        rf_we;
    logic        rj_eq_rkd;
    logic        br_taken;
    logic        send;

    la_decoder dec_i (
        .inst (inst),
        .dec  (dec)
    );

    // operands are read while the new instruction is in DECODE
    la_regfile rf_i (
        .clk    (clk),
        .raddr1 (dec.rj),
        .raddr2 (dec.rkd),
        .waddr  (dec_q.dest),
        .we     (rf_we),
        .wdata  (wb_data),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    la_alu alu_i (
        .alu_op (dec_q.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_out)
    );

    assign alu_src1  = dec_q.src1_is_pc ? pc : rj_val;
    assign alu_src2  = dec_q.src2_is_imm ? dec_q.imm : rkd_val;
    assign rj_eq_rkd = (rj_val == rkd_val);
    assign br_taken  = dec_q.is_jump | dec_q.is_jirl
                     | (dec_q.is_beq & rj_eq_rkd) | (dec_q.is_bne & ~rj_eq_rkd);
    assign br_target = (dec_q.is_jirl ? rj_val : pc) + dec_q.br_offs;

    // one request at a time, and only with a credit in hand
    assign send      = ((state == FETCH) || (state == MEM)) && (credits != '0);
    assign req_valid = send;
    assign req.addr  = (state == MEM) ? alu_res : pc;
    assign req.wdata = rkd_val;
    assign req.we    = (state == MEM) && dec_q.mem_we;
    assign req.src   = SRC_CORE;

    assign wb_data      = dec_q.res_from_mem ? load_data : alu_res;
    assign rf_we        = (state == WB) && dec_q.gr_we && (dec_q.dest != '0);
    assign retire_valid = (state == WB);
    assign retire.pc    = pc;
    assign retire.we    = rf_we;
    assign retire.wnum  = dec_q.dest;
    assign retire.wdata = wb_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            pc      <= RESET_PC;
            credits <= credit_t'(PORT_CREDITS);
        end else begin
            credits <= credits - credit_t'(send) + credit_t'(req_credit);
            case (state)
                IDLE: begin
                    if (run) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (send) begin
                        state <= FWAIT;
                    end
                end
                FWAIT: begin
                    if (rsp_valid) begin
                        state <= DECODE;
                    end
                end
                DECODE: state <= EXEC;
                EXEC: state <= (dec_q.is_load || dec_q.is_store) ? MEM : WB;
                MEM: begin
                    if (send) begin
                        state <= dec_q.is_load ? MWAIT : WB; // stores get no response
                    end
                end
                MWAIT: begin
                    if (rsp_valid) begin
                        state <= WB;
                    end
                end
                WB: begin
                    pc    <= next_pc;
                    state <= run ? FETCH : IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            FWAIT: begin
                if (rsp_valid) begin
                    inst <= rsp.rdata;
                end
            end
            DECODE: begin
                dec_q   <= dec;
                rj_val  <= rf_rdata1;
                rkd_val <= rf_rdata2;
            end
            EXEC: begin
                alu_res <= alu_out;
                next_pc <= br_taken ? br_target : pc + 32'd4;
            end
            MWAIT: begin
                if (rsp_valid) begin
                    load_data <= rsp.rdata;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
    import la_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire           core_req_valid,
    input  wire mem_req_t core_req,
    output logic          core_req_credit,
    input  wire           host_req_valid,
    input  wire mem_req_t host_req,
    output logic          host_req_credit,
    output logic          sram_req_valid,
    output mem_req_t      sram_req,
    input  wire           sram_credit,
    input  wire           sram_rsp_valid,
    input  wire mem_rsp_t sram_rsp,
    output logic          core_rsp_valid,
    output logic          host_rsp_valid,
    output mem_rsp_t      rsp
);

    logic [1:0] in_valid;
    mem_req_t   in_req [2];
    logic [1:0] slot_valid;
    mem_req_t   slot_req [2];
    src_t       last_gnt;
    src_t       gnt_idx;
    logic       send;
    credit_t    mem_credit;

    // ports are indexed by their src tag
    assign in_valid  = {host_req_valid, core_req_valid};
    assign in_req[0] = core_req;
    assign in_req[1] = host_req;

    assign gnt_idx = (&slot_valid) ? ~last_gnt : slot_valid[1];
    assign send    = (|slot_valid) && (mem_credit != '0);

    assign sram_req_valid  = send;
    assign sram_req        = slot_req[gnt_idx];
    assign core_req_credit = send && (gnt_idx == SRC_CORE);
    assign host_req_credit = send && (gnt_idx == SRC_HOST);

    assign core_rsp_valid = sram_rsp_valid && (sram_rsp.src == SRC_CORE);
    assign host_rsp_valid = sram_rsp_valid && (sram_rsp.src == SRC_HOST);
    assign rsp            = sram_rsp;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= '0;
            last_gnt   <= SRC_HOST;
            mem_credit <= credit_t'(SRAM_QDEPTH);
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (in_valid[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (send && (gnt_idx == src_t'(i))) begin
                    slot_valid[i] <= 1'b0;
                end
            end
            if (send) begin
                last_gnt <= gnt_idx;
            end
            mem_credit <= mem_credit - credit_t'(send) + credit_t'(sram_credit);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (in_valid[i]) begin
                slot_req[i]     <= in_req[i];
                slot_req[i].src <= src_t'(i); // tag by port, not by what the requester sent
            end
        end
    end

endmodule

`default_nettype wire

//--- unified_sram.sv
`timescale 1ns/10ps
`default_nettype none

module unified_sram
    import la_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire           req_valid,
    input  wire mem_req_t req,
    output logic          credit,
    output logic          rsp_valid,
    output mem_rsp_t      rsp
);

    mem_req_t               queue [SRAM_QDEPTH];
    logic [SRAM_QPTR_W-1:0] wr_ptr;
    logic [SRAM_QPTR_W-1:0] rd_ptr;
    credit_t                count;
    word_t                  storage [MEM_WORDS];
    mem_req_t               head;
    mem_idx_t               head_idx;
    logic                   deq;

    assign head     = queue[rd_ptr];
    assign head_idx = head.addr[9:2]; // upper address bits wrap
    assign deq      = (count != '0);
    assign credit   = deq;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            rsp_valid <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count     <= count + credit_t'(req_valid) - credit_t'(deq);
            rsp_valid <= deq && !head.we;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            queue[wr_ptr] <= req;
        end
        if (deq && head.we) begin
            storage[head_idx] <= head.wdata;
        end
        rsp.rdata <= storage[head_idx];
        rsp.src   <= head.src;
    end

endmodule

`default_nettype wire

//--- la_soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module la_soc_top
    import la_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire           run,
    input  wire           host_req_valid,
    input  wire mem_req_t host_req,
    output logic          host_req_credit,
    output logic          host_rsp_valid,
    output mem_rsp_t      host_rsp,
    output logic          retire_valid,
    output retire_t       retire
);

    logic     core_req_valid;
    logic     core_req_credit;
    logic     core_rsp_valid;
    logic     sram_req_valid;
    logic     sram_credit;
    logic     sram_rsp_valid;
    mem_req_t core_req;
    mem_req_t sram_req;
    mem_rsp_t sram_rsp;

    // the steered response bus is shared, each side qualifies it with its own valid
    la_core core_i (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .req_valid    (core_req_valid),
        .req          (core_req),
        .req_credit   (core_req_credit),
        .rsp_valid    (core_rsp_valid),
        .rsp          (host_rsp),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    mem_arbiter arb_i (
        .clk             (clk),
        .reset           (reset),
        .core_req_valid  (core_req_valid),
        .core_req        (core_req),
        .core_req_credit (core_req_credit),
        .host_req_valid  (host_req_valid),
        .host_req        (host_req),
        .host_req_credit (host_req_credit),
        .sram_req_valid  (sram_req_valid),
        .sram_req        (sram_req),
        .sram_credit     (sram_credit),
        .sram_rsp_valid  (sram_rsp_valid),
        .sram_rsp        (sram_rsp),
        .core_rsp_valid  (core_rsp_valid),
        .host_rsp_valid  (host_rsp_valid),
        .rsp             (host_rsp)
    );

    unified_sram sram_i (
        .clk       (clk),
        .reset     (reset),
        .req_valid (sram_req_valid),
        .req       (sram_req),
        .credit    (sram_credit),
        .rsp_valid (sram_rsp_valid),
        .rsp       (sram_rsp)
    );

endmodule

`default_nettype wire

//--- tb_la_soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_la_soc_top
    import la_pkg::*;
();

    logic     clk;
    logic     reset;
    logic     run;
    logic     host_req_valid;
    mem_req_t host_req;
    logic     host_req_credit;
    logic     host_rsp_valid;
    mem_rsp_t host_rsp;
    logic     retire_valid;
    retire_t  retire;

    int       host_credits = PORT_CREDITS;
    int       cycle_count = 0;
    logic [31:0] lfsr_state;
    word_t    prog [$];
    retire_t  exp_q [$];
    word_t    rm [32];          // expected register contents
    word_t    data_words [8];

    la_soc_top dut_i (
        .clk             (clk),
        .reset           (reset),
        .run             (run),
        .host_req_valid  (host_req_valid),
        .host_req        (host_req),
        .host_req_credit (host_req_credit),
        .host_rsp_valid  (host_rsp_valid),
        .host_rsp        (host_rsp),
        .retire_valid    (retire_valid),
        .retire          (retire)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            host_credits = PORT_CREDITS;
        end else if (host_req_credit) begin
            host_credits++;
        end
    end

    // the tests take about 1300 cycles, the limit is three times that
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= 4000) begin
            $display("timeout after %0d cycles, a response or retire never came", cycle_count);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    // taps 32, 22, 2 and 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        for (int i = 0; i < 32; i++) begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t pc_of(input int idx);
        return RESET_PC + word_t'(4 * idx);
    endfunction

    function automatic word_t data_addr(input int idx);
        return 32'h1c00_0200 + word_t'(4 * idx); // word 128 onward
    endfunction

    // x is rk, a shift amount, an immediate or an offset depending on the format
    function automatic word_t enc(input string mn, input int rd, input int rj, input int x);
        logic [4:0]  d;
        logic [4:0]  j;
        logic [25:0] v;
        d = rd[4:0];
        j = rj[4:0];
        v = x[25:0];
        case (mn)
            "add.w":   return {17'h00020, v[4:0], j, d};
            "sub.w":   return {17'h00022, v[4:0], j, d};
            "slt":     return {17'h00024, v[4:0], j, d};
            "sltu":    return {17'h00025, v[4:0], j, d};
            "nor":     return {17'h00028, v[4:0], j, d};
            "and":     return {17'h00029, v[4:0], j, d};
            "or":      return {17'h0002a, v[4:0], j, d};
            "xor":     return {17'h0002b, v[4:0], j, d};
            "slli.w":  return {17'h00081, v[4:0], j, d};
            "srli.w":  return {17'h00089, v[4:0], j, d};
            "srai.w":  return {17'h00091, v[4:0], j, d};
            "addi.w":  return {10'h00a, v[11:0], j, d};
            "ld.w":    return {10'h0a2, v[11:0], j, d};
            "st.w":    return {10'h0a6, v[11:0], j, d};
            "jirl":    return {6'h13, v[15:0], j, d};
            "beq":     return {6'h16, v[15:0], j, d};
            "bne":     return {6'h17, v[15:0], j, d};
            "b":       return {6'h14, v[15:0], v[25:16]}; // offs[25:16] goes low
            "bl":      return {6'h15, v[15:0], v[25:16]};
            "lu12i.w": return {7'h0a, v[19:0], d};
            default:   return 32'h0;
        endcase
    endfunction

    function automatic void add_inst(input word_t inst);
        prog.push_back(inst);
    endfunction

    function automatic void expect_rec(input int idx, input logic we, input reg_idx_t wnum,
                                       input word_t wdata);
        retire_t r;
        r.pc    = pc_of(idx);
        r.we    = we;
        r.wnum  = wnum;
        r.wdata = wdata;
        exp_q.push_back(r);
    endfunction

    function automatic void put_alu(input word_t inst, input reg_idx_t rd, input word_t value);
        if (rd != 5'd0) begin
            rm[rd] = value;
        end
        expect_rec(prog.size(), rd != 5'd0, rd, value);
        add_inst(inst);
    endfunction

    function automatic void put_loop();
        expect_rec(prog.size(), 1'b0, 5'd0, 32'h0);
        add_inst(enc("b", 0, 0, 0));
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic send_host_req(input word_t addr, input word_t data, input logic we);
        while (host_credits == 0) begin
            @(posedge clk);
            #1;
        end
        host_req.addr  = addr;
        host_req.wdata = data;
        host_req.we    = we;
        host_req.src   = SRC_CORE; // deliberately wrong, the arbiter retags by port
        host_req_valid = 1'b1;
        host_credits--;
        @(posedge clk);
        #1;
        host_req_valid = 1'b0;
    endtask

    task automatic host_write(input word_t addr, input word_t data);
        send_host_req(addr, data, 1'b1);
    endtask

    task automatic host_read_check(input word_t addr, input word_t expected);
        send_host_req(addr, 32'h0, 1'b0);
        @(posedge clk);
        while (!host_rsp_valid) begin
            @(posedge clk);
        end
        assert (host_rsp.rdata == expected)
        else report_mismatch("host_rsp.rdata", expected, host_rsp.rdata);
        #1;
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            host_write(pc_of(i), prog[i]);
        end
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        assert (got.pc == exp.pc) else report_mismatch("retire.pc", exp.pc, got.pc);
        assert (got.we == exp.we)
        else report_mismatch("retire.we", word_t'(exp.we), word_t'(got.we));
        if (exp.we) begin
            assert (got.wnum == exp.wnum)
            else report_mismatch("retire.wnum", word_t'(exp.wnum), word_t'(got.wnum));
            assert (got.wdata == exp.wdata)
            else report_mismatch("retire.wdata", exp.wdata, got.wdata);
        end
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            assert (!retire_valid) else report_mismatch("retire_valid", 32'h0, 32'h1);
            assert (!host_rsp_valid) else report_mismatch("host_rsp_valid", 32'h0, 32'h1);
        end
        #1;
    endtask

    task automatic run_and_trace();
        int idx;
        idx = 0;
        run = 1'b1;
        while (idx < exp_q.size()) begin
            @(posedge clk);
            if (retire_valid) begin
                check_retire(retire, exp_q[idx]);
                idx++;
            end
        end
        #1;
        run = 1'b0;
        // run was still high at the last WB, so the loop branch retires once more
        @(posedge clk);
        while (!retire_valid) begin
            @(posedge clk);
        end
        check_retire(retire, exp_q[exp_q.size() - 1]);
        check_quiet(10);
    endtask

    task automatic new_program();
        prog.delete();
        exp_q.delete();
        apply_reset();
    endtask

    task automatic test_host_rw();
        for (int i = 0; i < 8; i++) begin
            data_words[i] = rand_word();
            host_write(data_addr(i), data_words[i]);
        end
        for (int i = 0; i < 8; i++) begin
            host_read_check(data_addr(i), data_words[i]);
        end
    endtask

    task automatic test_alu_program();
        new_program();
        put_alu(enc("lu12i.w", 1, 0, 20'h12345), 1, {20'h12345, 12'h000});
        put_alu(enc("addi.w", 2, 1, 12'h678), 2, rm[1] + sext12(12'h678));
        put_alu(enc("addi.w", 3, 0, -3), 3, sext12(12'hffd));
        put_alu(enc("add.w", 4, 2, 3), 4, rm[2] + rm[3]);
        put_alu(enc("sub.w", 5, 3, 2), 5, rm[3] - rm[2]);
        put_alu(enc("slt", 6, 3, 2), 6, word_t'($signed(rm[3]) < $signed(rm[2])));
        put_alu(enc("sltu", 7, 3, 2), 7, word_t'(rm[3] < rm[2]));
        put_alu(enc("and", 8, 2, 3), 8, rm[2] & rm[3]);
        put_alu(enc("or", 9, 2, 3), 9, rm[2] | rm[3]);
        put_alu(enc("xor", 10, 2, 3), 10, rm[2] ^ rm[3]);
        put_alu(enc("nor", 11, 2, 3), 11, ~(rm[2] | rm[3]));
        put_alu(enc("slli.w", 12, 2, 4), 12, rm[2] << 4);
        put_alu(enc("srli.w", 13, 3, 28), 13, rm[3] >> 28);
        put_alu(enc("srai.w", 14, 3, 1), 14, word_t'($signed(rm[3]) >>> 1));
        put_alu(enc("addi.w", 0, 2, 5), 0, rm[2] + 32'd5); // r0 stays zero
        put_loop();
        load_program();
        run_and_trace();
    endtask

    task automatic test_mem_program();
        word_t w;
        w = rand_word();
        new_program();
        put_alu(enc("lu12i.w", 1, 0, 20'h1c000), 1, 32'h1c00_0000);
        put_alu(enc("lu12i.w", 2, 0, w[31:12]), 2, {w[31:12], 12'h000});
        put_alu(enc("addi.w", 2, 2, w[11:0]), 2, rm[2] + sext12(w[11:0]));
        expect_rec(prog.size(), 1'b0, 5'd0, 32'h0);
        add_inst(enc("st.w", 2, 1, 12'h300));
        put_alu(enc("ld.w", 3, 1, 12'h300), 3, rm[2]);
        put_loop();
        load_program();
        run_and_trace();
        host_read_check(RESET_PC + 32'h300, rm[2]);
    endtask

    task automatic test_branch_program();
        new_program();
        add_inst(enc("addi.w", 1, 0, 7));
        add_inst(enc("addi.w", 2, 0, 7));
        add_inst(enc("addi.w", 3, 0, 9));
        add_inst(enc("beq", 2, 1, 2));   // taken, skips word 4
        add_inst(enc("addi.w", 4, 0, 1));
        add_inst(enc("beq", 3, 1, 2));   // not taken
        add_inst(enc("bne", 3, 1, 2));   // taken, skips word 7
        add_inst(enc("addi.w", 4, 0, 2));
        add_inst(enc("bne", 2, 1, 5));   // not taken
        add_inst(enc("b", 0, 0, 2));     // skips word 10
        add_inst(enc("addi.w", 4, 0, 3));
        add_inst(enc("bl", 0, 0, 3));    // to word 14, links word 12
        add_inst(enc("addi.w", 6, 0, 12'h055));
        add_inst(enc("b", 0, 0, 0));
        add_inst(enc("jirl", 5, 1, 0));  // back to word 12
        expect_rec(0, 1'b1, 5'd1, 32'd7);
        expect_rec(1, 1'b1, 5'd2, 32'd7);
        expect_rec(2, 1'b1, 5'd3, 32'd9);
        expect_rec(3, 1'b0, 5'd0, 32'h0);
        expect_rec(5, 1'b0, 5'd0, 32'h0);
        expect_rec(6, 1'b0, 5'd0, 32'h0);
        expect_rec(8, 1'b0, 5'd0, 32'h0);
        expect_rec(9, 1'b0, 5'd0, 32'h0);
        expect_rec(11, 1'b1, 5'd1, pc_of(11) + 32'd4);
        expect_rec(14, 1'b1, 5'd5, pc_of(14) + 32'd4);
        expect_rec(12, 1'b1, 5'd6, 32'h55);
        expect_rec(13, 1'b0, 5'd0, 32'h0);
        load_program();
        run_and_trace();
    endtask

    task automatic test_run_with_host();
        new_program();
        put_alu(enc("addi.w", 7, 0, 12'h123), 7, 32'h123);
        put_alu(enc("ld.w", 8, 0, 12'h20c), 8, data_words[3]); // word 131
        put_alu(enc("add.w", 9, 7, 8), 9, rm[7] + rm[8]);
        put_alu(enc("xor", 10, 9, 8), 10, rm[9] ^ rm[8]);
        put_loop();
        load_program();
        fork
            run_and_trace();
            begin
                for (int i = 0; i < 8; i++) begin
                    host_read_check(data_addr(i), data_words[i]);
                end
            end
        join
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        run            = 1'b0;
        host_req_valid = 1'b0;
        host_req       = '0;
        lfsr_state     = 32'hfe19_b36b;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_quiet(20);
        test_host_rw();
        test_alu_program();
        test_mem_program();
        test_branch_program();
        test_run_with_host();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
la_pkg.sv
la_decoder.sv
la_regfile.sv
la_alu.sv
la_core.sv
mem_arbiter.sv
unified_sram.sv
la_soc_top.sv
tb_la_soc_top.sv
